// File: pdl_arbiter.sv
// ==========================================================
// PDL port a arbiter: round-robin between the stack and index
// peers, one pending slot each, read returns steered by tag.
// ==========================================================
`default_nettype none
`timescale 1ns/100ps

module pdl_arbiter (
   input  logic               clk_a,
   input  logic               reset,
   input  logic               stack_req,
   input  logic               stack_we,
   input  logic               index_req,
   input  logic               index_we,
   input  pdl_pkg::pdl_addr_t stack_addr,
   input  pdl_pkg::pdl_addr_t index_addr,
   input  pdl_pkg::pdl_word_t stack_wdata,
   input  pdl_pkg::pdl_word_t index_wdata,
   output logic               stack_rvalid,
   output logic               index_rvalid,
   output pdl_pkg::pdl_word_t rdata,
   output logic               wren_a,
   output logic               rden_a,
   output pdl_pkg::pdl_addr_t address_a,
   output pdl_pkg::pdl_word_t data_a,
   input  pdl_pkg::pdl_word_t q_a
);

   import pdl_pkg::*;

   logic      pend_s;                              // stack slot occupied.
   logic      pend_i;
   logic      pend_s_we;
   logic      pend_i_we;
   pdl_addr_t pend_s_addr;
   pdl_addr_t pend_i_addr;
   pdl_word_t pend_s_wdata;
   pdl_word_t pend_i_wdata;
   logic      last_grant;                          // tag of last peer served.
   logic      has_s;
   logic      has_i;
   logic      grant_s;
   logic      grant_i;
   logic      sel_we;
   pdl_addr_t sel_addr;
   pdl_word_t sel_wdata;
   logic      rd_q;                                // q_a valid this cycle.
   logic      rd_owner_q;

   assign has_s = pend_s | stack_req;
   assign has_i = pend_i | index_req;

   // ==========================================================
   // grant selection
   // ==========================================================
   // A pending request lost last cycle and is served first, so only
   // fresh strobes from both peers at once fall back to round robin.
   always_comb
   begin
      grant_s = 1'b0;
      grant_i = 1'b0;
      if (pend_s)
         grant_s = 1'b1;
      else if (pend_i)
         grant_i = 1'b1;
      else if (has_s && has_i)
      begin
         grant_s = (last_grant == pdl_peer_index);
         grant_i = (last_grant == pdl_peer_stack);
      end
      else
      begin
         grant_s = has_s;
         grant_i = has_i;
      end
   end

   always_comb
   begin
      if (grant_s)
      begin
         sel_we    = pend_s ? pend_s_we    : stack_we;
         sel_addr  = pend_s ? pend_s_addr  : stack_addr;
         sel_wdata = pend_s ? pend_s_wdata : stack_wdata;
      end
      else
      begin
         sel_we    = pend_i ? pend_i_we    : index_we;
         sel_addr  = pend_i ? pend_i_addr  : index_addr;
         sel_wdata = pend_i ? pend_i_wdata : index_wdata;
      end
   end

   assign wren_a    = (grant_s | grant_i) & sel_we;
   assign rden_a    = (grant_s | grant_i) & ~sel_we;
   assign address_a = sel_addr;
   assign data_a    = sel_wdata;

   // ==========================================================
   // pending slots and read tag pipeline
   // ==========================================================
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         pend_s     <= 1'b0;
         pend_i     <= 1'b0;
         last_grant <= pdl_peer_index;             // stack wins first.
         rd_q       <= 1'b0;
         rd_owner_q <= pdl_peer_stack;
      end
      else
      begin
         pend_s <= stack_req & ~grant_s;
         pend_i <= index_req & ~grant_i;
         if (grant_s)
            last_grant <= pdl_peer_stack;
         else if (grant_i)
            last_grant <= pdl_peer_index;
         rd_q       <= rden_a;
         rd_owner_q <= grant_i ? pdl_peer_index : pdl_peer_stack;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (stack_req && !grant_s)
      begin
         pend_s_we    <= stack_we;
         pend_s_addr  <= stack_addr;
         pend_s_wdata <= stack_wdata;
      end
      if (index_req && !grant_i)
      begin
         pend_i_we    <= index_we;
         pend_i_addr  <= index_addr;
         pend_i_wdata <= index_wdata;
      end
   end

   assign stack_rvalid = rd_q & (rd_owner_q == pdl_peer_stack);
   assign index_rvalid = rd_q & (rd_owner_q == pdl_peer_index);
   assign rdata        = q_a;

endmodule

`default_nettype wire

// File: pdl_index_unit.sv
// ==========================================================
// PDL index unit: base register plus offset addressing,
// registered port a requests and latched read results.
// ==========================================================
`default_nettype none
`timescale 1ns/100ps

module pdl_index_unit (
   input  logic               clk_a,
   input  logic               reset,
   input  logic               set_base,
   input  logic               idx_rd,
   input  logic               idx_wr,
   input  pdl_pkg::pdl_addr_t base_in,
   input  pdl_pkg::pdl_addr_t offset,
   input  pdl_pkg::pdl_word_t idx_wdata,
   output pdl_pkg::pdl_word_t idx_data,
   output logic               idx_done,
   output logic               index_req,
   output logic               index_we,
   output pdl_pkg::pdl_addr_t index_addr,
   output pdl_pkg::pdl_word_t index_wdata,
   input  logic               index_rvalid,
   input  pdl_pkg::pdl_word_t rdata
);

   import pdl_pkg::*;

   pdl_addr_t base_q;
   pdl_word_t idx_hold;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         base_q    <= '0;
         index_req <= 1'b0;
         index_we  <= 1'b0;
         idx_hold  <= '0;
      end
      else
      begin
         if (set_base)
            base_q <= base_in;                     // takes effect next op.
         index_req <= idx_rd | idx_wr;
         if (idx_wr || idx_rd)
            index_we <= idx_wr;
         if (index_rvalid)
            idx_hold <= rdata;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (idx_wr || idx_rd)
      begin
         index_addr  <= base_q + offset;           // wraps modulo 1024.
         index_wdata <= idx_wdata;
      end
   end

   assign idx_done = index_rvalid;
   assign idx_data = index_rvalid ? rdata : idx_hold;

endmodule

`default_nettype wire

// File: pdl_pkg.sv
// ==========================================================
// PDL package: memory geometry, word types and peer tags
// shared by the arbiter, the peers and the RAM.
// ==========================================================
`default_nettype none

package pdl_pkg;

   // ==========================================================
   // memory geometry
   // ==========================================================
   localparam int pdl_addr_w = 10;                 // 1k words.
   localparam int pdl_data_w = 32;
   localparam int pdl_depth  = 1 << pdl_addr_w;

   typedef logic [pdl_addr_w-1:0] pdl_addr_t;
   typedef logic [pdl_data_w-1:0] pdl_word_t;

   // ==========================================================
   // request owner tags
   // ==========================================================
   // The arbiter tags every port a read with the peer that issued it,
   // so that the return can be steered back to that peer.
   localparam logic pdl_peer_stack = 1'b0;         // push/pop engine.
   localparam logic pdl_peer_index = 1'b1;         // base plus offset engine.

endpackage

`default_nettype wire

// File: pdl_ram.sv
// ==========================================================
// PDL memory: 1k x 32 synchronous dual-port RAM, port a
// read/write, port b read only, registered outputs.
// ==========================================================
`default_nettype none
`timescale 1ns/100ps

module pdl_ram (
   input  logic               clk_a,
   input  logic               reset,
   input  logic               wren_a,
   input  logic               rden_a,
   input  pdl_pkg::pdl_addr_t address_a,
   input  pdl_pkg::pdl_addr_t address_b,
   input  pdl_pkg::pdl_word_t data_a,
   input  logic               rden_b,
   output pdl_pkg::pdl_word_t q_a,
   output pdl_pkg::pdl_word_t q_b
);

   import pdl_pkg::*;

   pdl_word_t mem [pdl_depth];

   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         mem[address_a] <= data_a;
   end

   // both read ports see the array before this edge's write.
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= mem[address_a];
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= mem[address_b];                    // host inspection port.
   end

endmodule

`default_nettype wire

// File: pdl_stack_unit.sv
// ==========================================================
// PDL stack unit: keeps the stack pointer and turns push/pop
// strobes into registered port a requests.
// ==========================================================
`default_nettype none
`timescale 1ns/100ps

module pdl_stack_unit (
   input  logic               clk_a,
   input  logic               reset,
   input  logic               push,
   input  logic               pop,
   input  pdl_pkg::pdl_word_t push_data,
   output pdl_pkg::pdl_word_t pop_data,
   output logic               pop_done,
   output pdl_pkg::pdl_addr_t sp,
   output logic               stack_req,
   output logic               stack_we,
   output pdl_pkg::pdl_addr_t stack_addr,
   output pdl_pkg::pdl_word_t stack_wdata,
   input  logic               stack_rvalid,
   input  pdl_pkg::pdl_word_t rdata
);

   import pdl_pkg::*;

   pdl_word_t pop_hold;                            // last popped word.

   // ==========================================================
   // pointer and request
   // ==========================================================
   // sp points at the next free word, so a push writes at sp and a
   // pop reads at sp - 1. Both wrap at the 10-bit width.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         sp        <= '0;
         stack_req <= 1'b0;
         stack_we  <= 1'b0;
      end
      else if (push)
      begin
         sp        <= sp + 1'b1;
         stack_req <= 1'b1;
         stack_we  <= 1'b1;
      end
      else if (pop)
      begin
         sp        <= sp - 1'b1;
         stack_req <= 1'b1;
         stack_we  <= 1'b0;
      end
      else
         stack_req <= 1'b0;
   end

   always_ff @(posedge clk_a)
   begin
      if (push)
      begin
         stack_addr  <= sp;
         stack_wdata <= push_data;
      end
      else if (pop)
         stack_addr <= sp - 1'b1;                  // 0 wraps to 1023.
   end

   // ==========================================================
   // pop return
   // ==========================================================
   always_ff @(posedge clk_a)
   begin
      if (reset)
         pop_hold <= '0;
      else if (stack_rvalid)
         pop_hold <= rdata;
   end

   assign pop_done = stack_rvalid;
   assign pop_data = stack_rvalid ? rdata : pop_hold;

endmodule

`default_nettype wire

// File: pdl_tb.sv
// ==========================================================
// PDL testbench: replays the trace file against the top level
// and checks pops, index reads, host reads and the pointer.
// ==========================================================
`default_nettype none
`timescale 1ns/100ps

module pdl_tb;

   import pdl_pkg::*;

   logic      clk_a;
   logic      reset;
   logic      push;
   logic      pop;
   logic      set_base;
   logic      idx_rd;
   logic      idx_wr;
   logic      rden_b;
   logic      pop_done;
   logic      idx_done;
   pdl_word_t push_data;
   pdl_word_t idx_wdata;
   pdl_word_t pop_data;
   pdl_word_t idx_data;
   pdl_word_t q_b;
   pdl_addr_t sp;
   pdl_addr_t base_in;
   pdl_addr_t offset;
   pdl_addr_t address_b;

   int        tr_gap[$];                           // idle cycles before op.
   int        tr_op[$];
   pdl_addr_t tr_addr[$];
   pdl_word_t tr_data[$];
   pdl_word_t tr_exp[$];
   pdl_word_t pop_exp[$];
   pdl_word_t idx_exp[$];
   pdl_word_t host_exp[$];
   int        pop_cyc[$];                          // strobe cycle per pop.
   int        idx_cyc[$];
   int        cyc = 0;
   int        cycle_limit = 100;
   int        lat;
   logic      host_wait = 1'b0;
   pdl_addr_t sp_model = '0;

   pdl_top pdl_top_inst (
      .clk_a     (clk_a),
      .reset     (reset),
      .push      (push),
      .pop       (pop),
      .push_data (push_data),
      .pop_data  (pop_data),
      .pop_done  (pop_done),
      .sp        (sp),
      .set_base  (set_base),
      .idx_rd    (idx_rd),
      .idx_wr    (idx_wr),
      .base_in   (base_in),
      .offset    (offset),
      .idx_wdata (idx_wdata),
      .idx_data  (idx_data),
      .idx_done  (idx_done),
      .rden_b    (rden_b),
      .address_b (address_b),
      .q_b       (q_b)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #4 clk_a = ~clk_a;                   // 8 ns period.
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("** Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("test failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "stopping the run");
   endtask

   always @(posedge clk_a)
   begin
      cyc <= cyc + 1;
      if (cyc > cycle_limit)
         abort_run("timeout: the trace did not finish within the cycle limit");
   end

   // ==========================================================
   // trace loading and replay
   // ==========================================================
   task automatic load_trace();
      int          fd;
      int          n;
      int          gap_v;
      int          op_v;
      logic [31:0] addr_v;
      logic [31:0] data_v;
      logic [31:0] exp_v;
      string       line;
      fd = $fopen("pdl_trace.txt", "r");
      if (fd == 0)
         abort_run("cannot open pdl_trace.txt for reading");
      while (!$feof(fd))
      begin
         n = $fgets(line, fd);
         if (n > 0 && $sscanf(line, "%d %d %h %h %h", gap_v, op_v, addr_v, data_v, exp_v) == 5)
         begin
            tr_gap.push_back(gap_v);
            tr_op.push_back(op_v);
            tr_addr.push_back(addr_v[9:0]);
            tr_data.push_back(data_v);
            tr_exp.push_back(exp_v);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_op(input int i);
      int op;
      op = tr_op[i];
      repeat (tr_gap[i]) @(posedge clk_a);
      @(posedge clk_a);
      case (op)
         0, 7:
         begin
            push      <= 1'b1;
            push_data <= tr_data[i];
            sp_model  = sp_model + 10'd1;
         end
         1, 6:
         begin
            pop      <= 1'b1;
            sp_model = sp_model - 10'd1;            // wraps 0 to 1023.
            pop_exp.push_back(tr_exp[i]);
            pop_cyc.push_back(cyc + 1);
         end
         2:
         begin
            set_base <= 1'b1;
            base_in  <= tr_addr[i];
         end
         3:
         begin
            idx_wr    <= 1'b1;
            offset    <= tr_addr[i];
            idx_wdata <= tr_data[i];
         end
         4:
         begin
            idx_rd <= 1'b1;
            offset <= tr_addr[i];
            idx_exp.push_back(tr_exp[i]);
            idx_cyc.push_back(cyc + 1);
         end
         5:
         begin
            rden_b    <= 1'b1;
            address_b <= tr_addr[i];
            host_exp.push_back(tr_exp[i]);
         end
         default:
            abort_run("unknown operation code in the trace");
      endcase
      if (op == 6 || op == 7)
      begin
         idx_rd <= 1'b1;                           // index read alongside.
         offset <= tr_addr[i];
         idx_exp.push_back(op == 6 ? tr_data[i] : tr_exp[i]);
         idx_cyc.push_back(cyc + 1);
      end
      @(posedge clk_a);
      push     <= 1'b0;
      pop      <= 1'b0;
      set_base <= 1'b0;
      idx_rd   <= 1'b0;
      idx_wr   <= 1'b0;
      rden_b   <= 1'b0;
      @(negedge clk_a);
      check_value("sp", 32'(sp), 32'(sp_model));
   endtask

   // ==========================================================
   // return monitor
   // ==========================================================
   always @(negedge clk_a)
   begin
      if (!reset)
      begin
         if (pop_done)
         begin
            if (pop_exp.size() == 0)
               abort_run("pop_done fired with no pop outstanding");
            check_value("pop_data", pop_data, pop_exp.pop_front());
            lat = cyc - pop_cyc.pop_front();
            if (lat > 3)
               abort_run("pop_done came more than 3 cycles after its pop");
         end
         if (idx_done)
         begin
            if (idx_exp.size() == 0)
               abort_run("idx_done fired with no index read outstanding");
            check_value("idx_data", idx_data, idx_exp.pop_front());
            lat = cyc - idx_cyc.pop_front();
            if (lat > 3)
               abort_run("idx_done came more than 3 cycles after its read");
         end
         if (host_wait)
            check_value("q_b", q_b, host_exp.pop_front());
         host_wait = rden_b;                       // q_b valid next cycle.
      end
   end

   initial
   begin
      reset     <= 1'b1;
      push      <= 1'b0;
      pop       <= 1'b0;
      set_base  <= 1'b0;
      idx_rd    <= 1'b0;
      idx_wr    <= 1'b0;
      rden_b    <= 1'b0;
      push_data <= '0;
      idx_wdata <= '0;
      base_in   <= '0;
      offset    <= '0;
      address_b <= '0;
      load_trace();
      cycle_limit = 20 * tr_op.size() + 100;
      repeat (10) @(posedge clk_a);
      reset <= 1'b0;
      @(negedge clk_a);
      check_value("q_b", q_b, 32'h0);
      check_value("pop_data", pop_data, 32'h0);
      check_value("idx_data", idx_data, 32'h0);
      check_value("sp", 32'(sp), 32'h0);
      for (int i = 0; i < tr_op.size(); i++)
         run_op(i);
      while (pop_exp.size() + idx_exp.size() + host_exp.size() != 0)
         @(negedge clk_a);
      repeat (4) @(posedge clk_a);
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: pdl_top.sv
// ==========================================================
// PDL top: stack and index peers share RAM port a through the
// arbiter, port b serves host reads.
// ==========================================================
`default_nettype none
`timescale 1ns/100ps

module pdl_top (
   input  logic               clk_a,
   input  logic               reset,
   input  logic               push,
   input  logic               pop,
   input  pdl_pkg::pdl_word_t push_data,
   output pdl_pkg::pdl_word_t pop_data,
   output logic               pop_done,
   output pdl_pkg::pdl_addr_t sp,
   input  logic               set_base,
   input  logic               idx_rd,
   input  logic               idx_wr,
   input  pdl_pkg::pdl_addr_t base_in,
   input  pdl_pkg::pdl_addr_t offset,
   input  pdl_pkg::pdl_word_t idx_wdata,
   output pdl_pkg::pdl_word_t idx_data,
   output logic               idx_done,
   input  logic               rden_b,
   input  pdl_pkg::pdl_addr_t address_b,
   output pdl_pkg::pdl_word_t q_b
);

   import pdl_pkg::*;

   logic      stack_req;
   logic      stack_we;
   pdl_addr_t stack_addr;
   pdl_word_t stack_wdata;
   logic      stack_rvalid;
   logic      index_req;
   logic      index_we;
   pdl_addr_t index_addr;
   pdl_word_t index_wdata;
   logic      index_rvalid;
   pdl_word_t rdata;                               // shared read return.
   logic      wren_a;
   logic      rden_a;
   pdl_addr_t address_a;
   pdl_word_t data_a;
   pdl_word_t q_a;

   pdl_stack_unit pdl_stack_unit_inst (
      .clk_a        (clk_a),
      .reset        (reset),
      .push         (push),
      .pop          (pop),
      .push_data    (push_data),
      .pop_data     (pop_data),
      .pop_done     (pop_done),
      .sp           (sp),
      .stack_req    (stack_req),
      .stack_we     (stack_we),
      .stack_addr   (stack_addr),
      .stack_wdata  (stack_wdata),
      .stack_rvalid (stack_rvalid),
      .rdata        (rdata)
   );

   pdl_index_unit pdl_index_unit_inst (
      .clk_a        (clk_a),
      .reset        (reset),
      .set_base     (set_base),
      .idx_rd       (idx_rd),
      .idx_wr       (idx_wr),
      .base_in      (base_in),
      .offset       (offset),
      .idx_wdata    (idx_wdata),
      .idx_data     (idx_data),
      .idx_done     (idx_done),
      .index_req    (index_req),
      .index_we     (index_we),
      .index_addr   (index_addr),
      .index_wdata  (index_wdata),
      .index_rvalid (index_rvalid),
      .rdata        (rdata)
   );

   pdl_arbiter pdl_arbiter_inst (
      .clk_a        (clk_a),
      .reset        (reset),
      .stack_req    (stack_req),
      .stack_we     (stack_we),
      .index_req    (index_req),
      .index_we     (index_we),
      .stack_addr   (stack_addr),
      .index_addr   (index_addr),
      .stack_wdata  (stack_wdata),
      .index_wdata  (index_wdata),
      .stack_rvalid (stack_rvalid),
      .index_rvalid (index_rvalid),
      .rdata        (rdata),
      .wren_a       (wren_a),
      .rden_a       (rden_a),
      .address_a    (address_a),
      .data_a       (data_a),
      .q_a          (q_a)
   );

   pdl_ram pdl_ram_inst (
      .clk_a        (clk_a),
      .reset        (reset),
      .wren_a       (wren_a),
      .rden_a       (rden_a),
      .address_a    (address_a),
      .address_b    (address_b),
      .data_a       (data_a),
      .rden_b       (rden_b),
      .q_a          (q_a),
      .q_b          (q_b)
   );

endmodule

`default_nettype wire

// File: pdl_trace.txt
# gap op addr data expect; gap and op decimal, the rest hex
# op 0 push, 1 pop, 2 set base, 3 index write, 4 index read, 5 host read, 6 pop+idx rd, 7 push+idx rd
0 0 000 11110000 00000000
0 0 000 22220001 00000000
0 0 000 33330002 00000000
1 1 000 00000000 33330002
0 1 000 00000000 22220001
0 1 000 00000000 11110000
0 2 3fc 00000000 00000000
0 3 008 a5a50004 00000000
2 5 004 00000000 a5a50004
0 4 008 00000000 a5a50004
0 3 003 deadbeef 00000000
2 1 000 00000000 deadbeef
0 0 000 cafe03ff 00000000
2 4 003 00000000 cafe03ff
0 3 003 5a5a5a5a 00000000
2 1 000 00000000 5a5a5a5a
0 0 000 77770000 00000000
0 0 000 88880001 00000000
0 2 000 00000000 00000000
1 6 004 a5a50004 88880001
1 7 3ff 99990000 77770000
2 5 000 00000000 99990000
0 1 000 00000000 99990000
2 5 3ff 00000000 77770000

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PDL testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f vlog.f --top-module pdl_tb -o pdl_sim; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/pdl_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "test passed"; then
   exit 0
fi
exit 1

// File: vlog.f
pdl_pkg.sv
pdl_ram.sv
pdl_arbiter.sv
pdl_stack_unit.sv
pdl_index_unit.sv
pdl_top.sv
pdl_tb.sv
